// File: noncomp_multifmt_slice.f
+incdir+verification
rtl/noncomp_pkg.sv
rtl/lane_req_if.sv
rtl/lane_rsp_if.sv
rtl/noncomp_dispatch.sv
rtl/noncomp_lane.sv
rtl/noncomp_pack.sv
rtl/noncomp_multifmt_slice.sv
verification/tb_noncomp_multifmt_slice.sv

// File: Bender.yml
package:
  name: noncomp_multifmt_slice

sources:
  - rtl/noncomp_pkg.sv
  - rtl/lane_req_if.sv
  - rtl/lane_rsp_if.sv
  - rtl/noncomp_dispatch.sv
  - rtl/noncomp_lane.sv
  - rtl/noncomp_pack.sv
  - rtl/noncomp_multifmt_slice.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_noncomp_multifmt_slice.sv

// File: verification/noncomp_model.svh
// ----------------------------------------------------------
// Reference model for the slice: per-element sign injection
// and MIN/MAX, then lane packing with NaN-boxing. Included
// inside the testbench module after the package import.
// ----------------------------------------------------------
`ifndef NONCOMP_MODEL_SVH
`define NONCOMP_MODEL_SVH

function automatic int width_of(fp_format_e fmt);
  case (fmt)
    FP16:    return 16;
    FP8:     return 8;
    default: return 32;
  endcase
endfunction

function automatic int exp_bits_of(fp_format_e fmt);
  return (fmt == FP32) ? 8 : 5;
endfunction

// Quiet NaN, positive sign, empty payload
function automatic logic [31:0] canonical_nan(fp_format_e fmt);
  case (fmt)
    FP16:    return 32'h0000_7e00;
    FP8:     return 32'h0000_007e;
    default: return 32'h7fc0_0000;
  endcase
endfunction

function automatic logic [31:0] slice_elem(logic [31:0] v, fp_format_e fmt, int k);
  int w;
  w = width_of(fmt);
  return (v >> (k * w)) & (32'hffff_ffff >> (32 - w));
endfunction

function automatic logic is_nan(logic [31:0] e, fp_format_e fmt);
  int          mb;
  logic [31:0] exp_max;
  mb      = width_of(fmt) - 1 - exp_bits_of(fmt);
  exp_max = (32'(1) << exp_bits_of(fmt)) - 1;
  return (((e >> mb) & exp_max) == exp_max) && ((e & ((32'(1) << mb) - 1)) != 0);
endfunction

// Signaling when the top mantissa bit is clear
function automatic logic is_snan(logic [31:0] e, fp_format_e fmt);
  int mb;
  mb = width_of(fmt) - 1 - exp_bits_of(fmt);
  return is_nan(e, fmt) && !e[mb-1];
endfunction

// Order on non-NaN values, -0 below +0
function automatic logic less_than(logic [31:0] a, logic [31:0] b, fp_format_e fmt);
  int          w;
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  w     = width_of(fmt);
  mag_a = a & (32'hffff_ffff >> (33 - w));
  mag_b = b & (32'hffff_ffff >> (33 - w));
  if (a[w-1] != b[w-1]) return a[w-1];
  if (a[w-1]) return mag_a > mag_b;
  return mag_a < mag_b;
endfunction

function automatic logic [31:0] lane_result(input logic [31:0] a, input logic [31:0] b,
                                            input noncomp_op_e op, input fp_format_e fmt,
                                            output logic nv);
  int          w;
  logic        sgn;
  logic [31:0] r;
  w  = width_of(fmt);
  nv = 1'b0;
  if (op == SGNJ || op == SGNJN || op == SGNJX) begin
    sgn = (op == SGNJ) ? b[w-1] : (op == SGNJN) ? !b[w-1] : (a[w-1] ^ b[w-1]);
    r   = (a & (32'hffff_ffff >> (33 - w))) | (32'(sgn) << (w - 1));
  end else begin
    nv = is_snan(a, fmt) || is_snan(b, fmt);
    if (is_nan(a, fmt) && is_nan(b, fmt)) r = canonical_nan(fmt);
    else if (is_nan(a, fmt)) r = b;
    else if (is_nan(b, fmt)) r = a;
    else if (op == MIN) r = less_than(a, b, fmt) ? a : b;
    else r = less_than(a, b, fmt) ? b : a;
  end
  return r;
endfunction

// Whole word: active lanes in place, all other bits ones
function automatic void expect_item(input logic [31:0] a, input logic [31:0] b,
                                    input noncomp_op_e op, input fp_format_e fmt,
                                    input logic vec, output logic [31:0] res,
                                    output fp_status_t st);
  int          w;
  int          lanes;
  logic        nv;
  logic [31:0] r;
  logic [31:0] mask;
  w     = width_of(fmt);
  lanes = vec ? 32 / w : 1;
  mask  = 32'hffff_ffff >> (32 - w);
  res   = '1;
  st    = '0;
  for (int k = 0; k < lanes; k++) begin
    r     = lane_result(slice_elem(a, fmt, k), slice_elem(b, fmt, k), op, fmt, nv);
    res   = (res & ~(mask << (k * w))) | (r << (k * w));
    st.nv = st.nv | nv;
  end
endfunction

`endif

// File: verification/tb_noncomp_multifmt_slice.sv
// ----------------------------------------------------------
// Testbench for the multi-format non-computational FP slice.
// LFSR stimulus with NaN/inf/zero bias, a queue of expected
// items from the model, back-pressure, latency and flush.
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_noncomp_multifmt_slice import noncomp_pkg::*; ();

  `include "noncomp_model.svh"

  localparam int REPS        = 4;
  localparam int NAN_ITEMS   = 48;
  localparam int BP_ITEMS    = 200;
  localparam int LAT_ITEMS   = 8;
  localparam int FLUSH_ITEMS = 3;
  localparam int TOTAL_ITEMS = 30 * REPS + NAN_ITEMS + BP_ITEMS + LAT_ITEMS + FLUSH_ITEMS;
  localparam int TIMEOUT_CYCLES = 8 * TOTAL_ITEMS + 100;

  logic                clk = 1'b0;
  logic                rst_n_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic [FLEN-1:0]     op_a_i;
  logic [FLEN-1:0]     op_b_i;
  noncomp_op_e         op_i;
  fp_format_e          fmt_i;
  logic                vectorial_i;
  logic [TAG_BITS-1:0] tag_i;
  logic                flush_i;
  logic                out_valid_o;
  logic                out_ready_i;
  logic [FLEN-1:0]     result_o;
  fp_status_t          status_o;
  logic [TAG_BITS-1:0] tag_o;
  logic                busy_o;

  logic [31:0]         lfsr_state = 32'h2533_da02;
  logic [TAG_BITS-1:0] tag_ctr = '0;
  logic                rand_ready = 1'b0;
  logic                timed_run = 1'b0;
  string               cur_test = "reset";
  int                  cycle = 0;
  int                  mismatch_cnt = 0;
  int                  fail_cnt = 0;

  // Expected items, in acceptance order
  logic [31:0]         res_q [$];
  fp_status_t          st_q [$];
  logic [TAG_BITS-1:0] tag_q [$];
  string               name_q [$];
  int                  cyc_q [$];
  logic                timed_q [$];

  always #50 clk = ~clk;

  noncomp_multifmt_slice u_noncomp_multifmt_slice (
    .clk_i (clk),
    .*
  );

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Kind 0 qNaN, 1 sNaN, 2 infinity, 3 zero, else any value
  function automatic logic [31:0] make_elem(fp_format_e fmt, int kind);
    int          w;
    int          mb;
    logic [31:0] exp_all;
    logic [31:0] man;
    logic [31:0] sgn;
    logic [31:0] v;
    w       = width_of(fmt);
    mb      = w - 1 - exp_bits_of(fmt);
    exp_all = ((32'(1) << exp_bits_of(fmt)) - 1) << mb;
    sgn     = rand_bits(1) << (w - 1);
    man     = rand_bits(mb);
    case (kind)
      0: v = sgn | exp_all | man | (32'(1) << (mb - 1));
      1: begin
        man = man & ~(32'(1) << (mb - 1));
        v   = sgn | exp_all | ((man == 0) ? 32'd1 : man);
      end
      2: v = sgn | exp_all;
      3: v = sgn;
      default: v = rand_bits(w);
    endcase
    return v;
  endfunction

  // Negative kind draws a biased kind for every element
  function automatic logic [31:0] make_operand(fp_format_e fmt, int kind);
    int          w;
    int          kk;
    logic [31:0] v;
    w = width_of(fmt);
    v = '0;
    for (int k = 0; k < 32 / w; k++) begin
      kk = (kind >= 0) ? kind : int'(rand_bits(4));
      v  = v | (make_elem(fmt, kk) << (k * w));
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge clk);
    if (rand_ready) out_ready_i <= (rand_bits(2) != 0);
  endtask

  task automatic send_item(input noncomp_op_e op, input fp_format_e fmt, input logic vec,
                           input logic [31:0] a, input logic [31:0] b);
    in_valid_i  <= 1'b1;
    op_i        <= op;
    fmt_i       <= fmt;
    vectorial_i <= vec;
    op_a_i      <= a;
    op_b_i      <= b;
    tag_i       <= tag_ctr;
    tick();
    while (!in_ready_o) tick();
    in_valid_i <= 1'b0;
    tag_ctr = tag_ctr + 1'b1;
  endtask

  task automatic send_random(input noncomp_op_e op, input fp_format_e fmt, input logic vec);
    send_item(op, fmt, vec, make_operand(fmt, -1), make_operand(fmt, -1));
  endtask

  // Poll the expected queue at falling edges until it is empty
  task automatic wait_drain();
    @(negedge clk);
    while (res_q.size() != 0) begin
      tick();
      @(negedge clk);
    end
    tick();
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0b, actual %0b", name, exp_v, act_v);
    end
  endtask

  // ----------------------------------------------------------
  // Scoreboard, sampled on the edge where handshakes happen
  // ----------------------------------------------------------
  always @(posedge clk) begin : scoreboard
    logic [31:0]         e_res;
    fp_status_t          e_st;
    logic [TAG_BITS-1:0] e_tag;
    string               e_name;
    int                  e_cyc;
    logic                e_timed;
    if (rst_n_i && flush_i) begin
      res_q.delete();
      st_q.delete();
      tag_q.delete();
      name_q.delete();
      cyc_q.delete();
      timed_q.delete();
    end else if (rst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        if (res_q.size() == 0) begin
          fail_cnt++;
          $display("Output with tag %0h appeared with no item pending", tag_o);
        end else begin
          e_res   = res_q.pop_front();
          e_st    = st_q.pop_front();
          e_tag   = tag_q.pop_front();
          e_name  = name_q.pop_front();
          e_cyc   = cyc_q.pop_front();
          e_timed = timed_q.pop_front();
          if (result_o !== e_res) begin
            mismatch_cnt++;
            $display("MISMATCH %s result: expected %08h, actual %08h", e_name, e_res, result_o);
          end
          if (status_o !== e_st) begin
            mismatch_cnt++;
            $display("MISMATCH %s status: expected %05b, actual %05b", e_name, e_st, status_o);
          end
          if (tag_o !== e_tag) begin
            mismatch_cnt++;
            $display("MISMATCH %s tag: expected %0h, actual %0h", e_name, e_tag, tag_o);
          end
          if (e_timed && (cycle - e_cyc != NUM_PIPE_REGS)) begin
            mismatch_cnt++;
            $display("MISMATCH %s latency: expected %0d, actual %0d", e_name,
                     NUM_PIPE_REGS, cycle - e_cyc);
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        expect_item(op_a_i, op_b_i, op_i, fmt_i, vectorial_i, e_res, e_st);
        res_q.push_back(e_res);
        st_q.push_back(e_st);
        tag_q.push_back(tag_i);
        name_q.push_back(cur_test);
        cyc_q.push_back(cycle);
        timed_q.push_back(timed_run);
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : main
    fp_format_e fmt;
    int         ka;
    int         kb;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    op_i        = SGNJ;
    fmt_i       = FP32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_bit("reset out_valid_o", 1'b0, out_valid_o);
    check_bit("reset busy_o", 1'b0, busy_o);
    check_bit("reset in_ready_o", 1'b1, in_ready_o);
    tick();

    // Scalar in every format, then FP32 with the vector flag
    cur_test <= "scalar";
    for (int f = 0; f < 3; f++)
      for (int o = 0; o < 5; o++)
        repeat (REPS) send_random(noncomp_op_e'(o), fp_format_e'(f), 1'b0);
    cur_test <= "fp32_vectorial";
    for (int o = 0; o < 5; o++)
      repeat (REPS) send_random(noncomp_op_e'(o), FP32, 1'b1);

    cur_test <= "vector";
    for (int f = 1; f < 3; f++)
      for (int o = 0; o < 5; o++)
        repeat (REPS) send_random(noncomp_op_e'(o), fp_format_e'(f), 1'b1);

    // Operand kinds qNaN, sNaN and ordinary number in pairs
    cur_test <= "nan_rules";
    for (int f = 0; f < 3; f++) begin
      for (int o = MIN; o <= MAX; o++) begin
        for (int ia = 0; ia < 3; ia++) begin
          for (int ib = 0; ib < 3; ib++) begin
            if (ia == 2 && ib == 2) continue;
            fmt = fp_format_e'(f);
            ka  = (ia == 2) ? 4 : ia;
            kb  = (ib == 2) ? 4 : ib;
            send_item(noncomp_op_e'(o), fmt, f != 0, make_operand(fmt, ka),
                      make_operand(fmt, kb));
          end
        end
      end
    end

    cur_test   <= "back_pressure";
    rand_ready = 1'b1;
    for (int i = 0; i < BP_ITEMS; i++) begin
      while (rand_bits(2) == 0) tick();
      send_random(noncomp_op_e'(rand_bits(3) % 5), fp_format_e'(rand_bits(2) % 3),
                  rand_bits(1) != 0);
    end
    wait_drain();
    rand_ready = 1'b0;
    out_ready_i <= 1'b1;
    tick();

    cur_test  <= "latency";
    timed_run <= 1'b1;
    repeat (LAT_ITEMS) send_random(noncomp_op_e'(rand_bits(3) % 5), FP16, 1'b1);
    wait_drain();
    timed_run <= 1'b0;

    // Fill both stages under a stall, then flush them away
    cur_test <= "flush";
    out_ready_i <= 1'b0;
    repeat (2) send_random(MAX, FP8, 1'b1);
    flush_i <= 1'b1;
    tick();
    flush_i <= 1'b0;
    @(negedge clk);
    check_bit("flush out_valid_o", 1'b0, out_valid_o);
    check_bit("flush busy_o", 1'b0, busy_o);
    tick();
    out_ready_i <= 1'b1;
    send_random(SGNJX, FP16, 1'b1);
    wait_drain();
    repeat (4) tick();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/noncomp_multifmt_slice.sv
// ----------------------------------------------------------
// Multi-format non-computational FP slice: sign injection and
// MIN/MAX on one FP32, two FP16 or four FP8 values per beat.
// Valid/ready on both sides, two-cycle lane pipeline.
// ----------------------------------------------------------
`timescale 1ns/1ps

module noncomp_multifmt_slice import noncomp_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [FLEN-1:0]     op_a_i,
  input  logic [FLEN-1:0]     op_b_i,
  input  noncomp_op_e         op_i,
  input  fp_format_e          fmt_i,
  input  logic                vectorial_i,
  input  logic [TAG_BITS-1:0] tag_i,
  input  logic                flush_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [FLEN-1:0]     result_o,
  output fp_status_t          status_o,
  output logic [TAG_BITS-1:0] tag_o,
  output logic                busy_o
);

  lane_req_if req_if [NUM_LANES] ();
  lane_rsp_if rsp_if [NUM_LANES] ();

  noncomp_dispatch u_noncomp_dispatch (
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vectorial_i (vectorial_i),
    .tag_i       (tag_i),
    .req_o       (req_if)
  );

  // Lane widths come out as 32, 16, 8, 8
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    noncomp_lane #(
      .LaneWidth (lane_width(k))
    ) u_noncomp_lane (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .req_i   (req_if[k]),
      .rsp_o   (rsp_if[k])
    );
  end

  noncomp_pack u_noncomp_pack (
    .rsp_i       (rsp_if),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

endmodule

// File: rtl/noncomp_pack.sv
// ----------------------------------------------------------
// Output side of the slice. Places each active lane's result
// at its slot, NaN-boxes the rest with ones, ORs the flags
// and drives the downstream handshake from lane 0.
// ----------------------------------------------------------
`timescale 1ns/1ps

module noncomp_pack import noncomp_pkg::*; (
  lane_rsp_if.pack            rsp_i [NUM_LANES],
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [FLEN-1:0]     result_o,
  output fp_status_t          status_o,
  output logic [TAG_BITS-1:0] tag_o,
  output logic                busy_o
);

  lane_aux_t            out_aux;
  logic [NUM_LANES-1:0] lane_active;
  logic [NUM_LANES-1:0] lane_busy;
  logic [FLEN-1:0]      lane_result [NUM_LANES];
  fp_status_t           lane_status [NUM_LANES];

  // Lane 0 always carries the item, so its aux describes it
  assign out_aux = rsp_i[0].aux;

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane_rsp
    assign lane_active[k] = (k == 0) ||
                            (out_aux.vectorial && (k < num_lanes(out_aux.fmt)));

    // Idle lanes get no ready, which keeps busy lanes in step
    assign rsp_i[k].ready = out_ready_i & lane_active[k];

    assign lane_result[k] = rsp_i[k].result;
    assign lane_status[k] = rsp_i[k].status;
    assign lane_busy[k]   = rsp_i[k].busy;
  end

  always_comb begin : assemble
    int unsigned     fw;
    logic [FLEN-1:0] slot_mask;

    fw        = fp_width(out_aux.fmt);
    slot_mask = {FLEN{1'b1}} >> (FLEN - fw);
    result_o  = '1;
    status_o  = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (lane_active[k]) begin
        result_o = (result_o & ~(slot_mask << (k * fw))) |
                   ((lane_result[k] & slot_mask) << (k * fw));
        status_o = status_o | lane_status[k];
      end
    end
  end

  assign out_valid_o = rsp_i[0].valid;
  assign tag_o       = rsp_i[0].tag;
  assign busy_o      = |lane_busy;

endmodule

// File: rtl/noncomp_lane.sv
// ----------------------------------------------------------
// One lane of the slice. Computes sign injection and MIN/MAX
// at the requested format, then carries result, flags, tag
// and aux through NUM_PIPE_REGS handshaked register stages.
// ----------------------------------------------------------
`timescale 1ns/1ps

module noncomp_lane import noncomp_pkg::*; #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  lane_req_if.lane req_i,
  lane_rsp_if.lane rsp_o
);

  fp_format_e           lane_fmt;
  logic [LaneWidth-1:0] op_res;
  fp_status_t           op_status;

  // Stage 0 is the combinational input, stage N the output
  logic                 pipe_valid  [0:NUM_PIPE_REGS];
  logic                 pipe_ready  [0:NUM_PIPE_REGS];
  logic [LaneWidth-1:0] pipe_result [0:NUM_PIPE_REGS];
  fp_status_t           pipe_status [0:NUM_PIPE_REGS];
  logic [TAG_BITS-1:0]  pipe_tag    [0:NUM_PIPE_REGS];
  lane_aux_t            pipe_aux    [0:NUM_PIPE_REGS];

  // Formats wider than the lane fall back to the widest that fits
  assign lane_fmt = (fp_width(req_i.fmt) <= LaneWidth) ? req_i.fmt :
                    (LaneWidth >= 32) ? FP32 :
                    (LaneWidth >= 16) ? FP16 : FP8;

  // ----------------------------------------------------------
  // Operation
  // ----------------------------------------------------------
  always_comb begin : compute
    int unsigned          fw;
    int unsigned          mb;
    logic [LaneWidth-1:0] a, b;
    logic [LaneWidth-1:0] low_mask, mag_mask, sign_bit, man_mask, exp_ones, qbit;
    logic                 sign_a, sign_b, sign_res;
    logic                 nan_a, nan_b, snan_a, snan_b, a_lt_b;

    fw       = fp_width(lane_fmt);
    mb       = fw - 1 - exp_bits(lane_fmt);
    low_mask = {LaneWidth{1'b1}} >> (LaneWidth - fw);
    mag_mask = low_mask >> 1;
    sign_bit = low_mask & ~mag_mask;
    man_mask = (LaneWidth'(1) << mb) - LaneWidth'(1);
    exp_ones = mag_mask & ~man_mask;
    qbit     = LaneWidth'(1) << (mb - 1);

    a      = req_i.op_a[LaneWidth-1:0] & low_mask;
    b      = req_i.op_b[LaneWidth-1:0] & low_mask;
    sign_a = |(a & sign_bit);
    sign_b = |(b & sign_bit);

    nan_a  = ((a & exp_ones) == exp_ones) && ((a & man_mask) != '0);
    nan_b  = ((b & exp_ones) == exp_ones) && ((b & man_mask) != '0);
    snan_a = nan_a && ((a & qbit) == '0);
    snan_b = nan_b && ((b & qbit) == '0);

    // Sign first, so -0 orders below +0
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = (a & mag_mask) > (b & mag_mask);
    end else begin
      a_lt_b = (a & mag_mask) < (b & mag_mask);
    end

    case (req_i.op)
      SGNJN:   sign_res = ~sign_b;
      SGNJX:   sign_res = sign_a ^ sign_b;
      default: sign_res = sign_b;
    endcase

    op_status = '0;
    if ((req_i.op == MIN) || (req_i.op == MAX)) begin
      op_status.nv = snan_a | snan_b;
      if (nan_a && nan_b) begin
        op_res = exp_ones | qbit;
      end else if (nan_a) begin
        op_res = b;
      end else if (nan_b) begin
        op_res = a;
      end else begin
        op_res = (a_lt_b ^ (req_i.op == MAX)) ? a : b;
      end
    end else begin
      op_res = (a & mag_mask) | ({LaneWidth{sign_res}} & sign_bit);
    end
  end

  // ----------------------------------------------------------
  // Pipeline
  // ----------------------------------------------------------
  assign pipe_valid[0]  = req_i.valid;
  assign pipe_result[0] = op_res;
  assign pipe_status[0] = op_status;
  assign pipe_tag[0]    = req_i.tag;
  assign pipe_aux[0]    = req_i.aux;
  assign req_i.ready    = pipe_ready[0];

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    logic reg_en;

    // Advance when the next stage moves on or is empty
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];
    assign reg_en        = pipe_ready[i] & pipe_valid[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid[i+1] <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        pipe_result[i+1] <= pipe_result[i];
        pipe_status[i+1] <= pipe_status[i];
        pipe_tag[i+1]    <= pipe_tag[i];
        pipe_aux[i+1]    <= pipe_aux[i];
      end
    end
  end

  assign pipe_ready[NUM_PIPE_REGS] = rsp_o.ready;

  assign rsp_o.valid  = pipe_valid[NUM_PIPE_REGS];
  assign rsp_o.result = FLEN'(pipe_result[NUM_PIPE_REGS]);
  assign rsp_o.status = pipe_status[NUM_PIPE_REGS];
  assign rsp_o.tag    = pipe_tag[NUM_PIPE_REGS];
  assign rsp_o.aux    = pipe_aux[NUM_PIPE_REGS];

  always_comb begin : busy_or
    rsp_o.busy = 1'b0;
    for (int i = 1; i <= NUM_PIPE_REGS; i++) begin
      rsp_o.busy = rsp_o.busy | pipe_valid[i];
    end
  end

  // Held output must not change until taken
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.valid && !rsp_o.ready && !flush_i |=>
      rsp_o.valid && $stable(rsp_o.result) && $stable(rsp_o.tag))
    else $error("Lane output changed while stalled");

  a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !rsp_o.valid)
    else $error("Lane output valid after flush");

endmodule

// File: rtl/noncomp_dispatch.sv
// ----------------------------------------------------------
// Input side of the slice. Cuts both operands into per-lane
// slices and raises each lane's valid only when the lane is
// used by the current format and vector mode.
// ----------------------------------------------------------
`timescale 1ns/1ps

module noncomp_dispatch import noncomp_pkg::*; (
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [FLEN-1:0]     op_a_i,
  input  logic [FLEN-1:0]     op_b_i,
  input  noncomp_op_e         op_i,
  input  fp_format_e          fmt_i,
  input  logic                vectorial_i,
  input  logic [TAG_BITS-1:0] tag_i,
  lane_req_if.dispatch        req_o [NUM_LANES]
);

  logic [NUM_LANES-1:0] lane_used;

  // Upstream handshake follows lane 0
  assign in_ready_o = req_o[0].ready;

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane_req
    // Scalars only ever occupy lane 0
    assign lane_used[k] = (k == 0) || (vectorial_i && (k < num_lanes(fmt_i)));

    assign req_o[k].valid = in_valid_i & lane_used[k];
    assign req_o[k].op_a  = op_a_i >> (k * fp_width(fmt_i));
    assign req_o[k].op_b  = op_b_i >> (k * fp_width(fmt_i));
    assign req_o[k].op    = op_i;
    assign req_o[k].fmt   = fmt_i;
    assign req_o[k].tag   = tag_i;
    assign req_o[k].aux   = '{fmt: fmt_i, vectorial: vectorial_i};

    // A narrow lane must never see a format wider than itself,
    // and an active upper lane has room whenever lane 0 does
    always_comb begin : chk_lane
      assert #0 (!req_o[k].valid || (fp_width(fmt_i) <= lane_width(k)))
        else $error("Lane %0d got a format wider than the lane", k);
      assert #0 (!req_o[k].valid || !req_o[0].ready || req_o[k].ready)
        else $error("Lane %0d out of step with lane 0", k);
    end
  end

endmodule

// File: rtl/lane_rsp_if.sv
// ----------------------------------------------------------
// Response channel from one lane to the result packer, with
// a valid/ready handshake and the lane's busy indication.
// ----------------------------------------------------------
`timescale 1ns/1ps

interface lane_rsp_if import noncomp_pkg::*; ();

  logic                valid;
  logic                ready;
  logic [FLEN-1:0]     result;
  fp_status_t          status;
  logic [TAG_BITS-1:0] tag;
  lane_aux_t           aux;
  logic                busy;

  modport lane (output valid, result, status, tag, aux, busy, input ready);

  modport pack (input valid, result, status, tag, aux, busy, output ready);

endinterface

// File: rtl/lane_req_if.sv
// ----------------------------------------------------------
// Request channel from the dispatcher into one lane, with a
// valid/ready handshake. Payload is held while stalled.
// ----------------------------------------------------------
`timescale 1ns/1ps

interface lane_req_if import noncomp_pkg::*; ();

  logic                valid;
  logic                ready;
  logic [FLEN-1:0]     op_a;
  logic [FLEN-1:0]     op_b;
  noncomp_op_e         op;
  fp_format_e          fmt;
  logic [TAG_BITS-1:0] tag;
  lane_aux_t           aux;

  modport dispatch (output valid, op_a, op_b, op, fmt, tag, aux, input ready);

  modport lane (input valid, op_a, op_b, op, fmt, tag, aux, output ready);

endinterface

// File: rtl/noncomp_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the multi-format non-computational
// FP slice: formats, operations, status and pipeline sizing.
// Imported by every RTL module and interface of the slice.
// ----------------------------------------------------------
package noncomp_pkg;

  // Datapath sizing
  localparam int unsigned FLEN          = 32;
  localparam int unsigned NUM_LANES     = 4;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_BITS      = 4;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX
  } noncomp_op_e;

  // IEEE exception flags, only nv is produced by this group
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // Side information that follows each item down a lane
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } lane_aux_t;

  // ----------------------------------------------------------
  // Format properties
  // ----------------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    case (fmt)
      FP16, FP8: return 5;
      default:   return 8;
    endcase
  endfunction

  function automatic int unsigned num_lanes(fp_format_e fmt);
    return FLEN / fp_width(fmt);
  endfunction

  // Widest format a given lane ever has to hold
  function automatic int unsigned lane_width(int unsigned lane);
    if (lane < num_lanes(FP32)) return fp_width(FP32);
    if (lane < num_lanes(FP16)) return fp_width(FP16);
    return fp_width(FP8);
  endfunction

endpackage
